//--- all.f
logic/spi_mem_pkg.sv
logic/sdram_cmd_pkg.sv
logic/sdram_timer.sv
logic/sdram_seq.sv
logic/word_packer.sv
logic/spi_rw_slave.sv
logic/spi_sdram_top.sv
sim/sdram_model.sv
sim/spi_sdram_chk.sv
sim/tb_spi_sdram.sv

//--- logic/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

  // {csn, rasn, casn, wen}
  typedef enum logic [3:0] {
    cmd_nop       = 4'b0111,
    cmd_active    = 4'b0011,
    cmd_read      = 4'b0101,
    cmd_write     = 4'b0100,
    cmd_precharge = 4'b0010,
    cmd_refresh   = 4'b0001,
    cmd_load_mode = 4'b0000
  } sdram_cmd_t;

  typedef enum logic [3:0] {
    st_reset, st_init_wait, st_init_pre, st_init_ref1, st_init_ref2, st_init_mode,
    st_idle, st_refresh, st_activate, st_cas_wait, st_capture, st_precharge, st_ack
  } seq_state_t;

  typedef logic [12:0] row_t; // also the width of the A pins
  typedef logic [8:0] col_t;
  typedef logic [1:0] bank_t;

endpackage

//--- logic/sdram_seq.sv
`timescale 1ns/1ps

module sdram_seq #(
  parameter int t_rcd = 2,
  parameter int cas_lat = 2,
  parameter int t_rp = 2,
  parameter int t_rfc = 7,
  parameter int init_cycles = 10000,
  parameter int delay_w = 14
) (
  input  logic clk,
  input  logic rst,
  input  logic mem_req,
  input  logic mem_we,
  input  spi_mem_pkg::word_addr_t mem_addr,
  input  spi_mem_pkg::mem_word_t mem_wdata,
  output logic mem_ack,
  output spi_mem_pkg::mem_word_t mem_rdata,
  output logic delay_load,
  output logic [delay_w-1:0] delay_count,
  input  logic delay_done,
  input  logic refresh_due,
  output logic refresh_clr,
  output logic sdram_cke,
  output logic sdram_csn,
  output logic sdram_rasn,
  output logic sdram_casn,
  output logic sdram_wen,
  output sdram_cmd_pkg::bank_t sdram_ba,
  output sdram_cmd_pkg::row_t sdram_a,
  output logic [1:0] sdram_dqm,
  output spi_mem_pkg::mem_word_t sdram_dq_out,
  output logic sdram_dq_oe,
  input  spi_mem_pkg::mem_word_t sdram_dq_in
);

  // burst length 1, sequential, cas latency from the parameter
  localparam sdram_cmd_pkg::row_t mode_word = {3'b000, 1'b0, 2'b00, 3'(cas_lat), 1'b0, 3'b000};

  sdram_cmd_pkg::seq_state_t state, state_d;
  sdram_cmd_pkg::sdram_cmd_t cmd_q, cmd_d;
  sdram_cmd_pkg::bank_t bank, ba_d;
  sdram_cmd_pkg::row_t row, a_d;
  sdram_cmd_pkg::col_t col;
  logic cke_d, oe_d, ack_d, capture;

  assign bank = {1'b0, mem_addr[22]};
  assign row = mem_addr[21:9];
  assign col = mem_addr[8:0];
  assign {sdram_csn, sdram_rasn, sdram_casn, sdram_wen} = cmd_q;
  assign sdram_dqm = 2'b00;

  // a delay of n loaded here puts n + 1 cycles between two commands on the pins
  always_comb
  begin
    state_d = state;
    cmd_d = sdram_cmd_pkg::cmd_nop;
    cke_d = sdram_cke;
    oe_d = 1'b0;
    ack_d = mem_ack;
    capture = 1'b0;
    ba_d = sdram_ba;
    a_d = sdram_a;
    delay_load = 1'b0;
    delay_count = '0;
    refresh_clr = 1'b0;
    case (state)
      sdram_cmd_pkg::st_reset:
      begin
        delay_load = 1'b1;
        delay_count = delay_w'(init_cycles - 2); // cke low for init_cycles
        state_d = sdram_cmd_pkg::st_init_wait;
      end
      sdram_cmd_pkg::st_init_wait:
        if (delay_done)
        begin
          cke_d = 1'b1;
          cmd_d = sdram_cmd_pkg::cmd_precharge;
          a_d = 13'h0400; // a10, all banks
          delay_load = 1'b1;
          delay_count = delay_w'(t_rp - 1);
          state_d = sdram_cmd_pkg::st_init_pre;
        end
      sdram_cmd_pkg::st_init_pre, sdram_cmd_pkg::st_init_ref1:
        if (delay_done)
        begin
          cmd_d = sdram_cmd_pkg::cmd_refresh;
          delay_load = 1'b1;
          delay_count = delay_w'(t_rfc - 1);
          state_d = (state == sdram_cmd_pkg::st_init_pre) ? sdram_cmd_pkg::st_init_ref1
                                                           : sdram_cmd_pkg::st_init_ref2;
        end
      sdram_cmd_pkg::st_init_ref2:
        if (delay_done)
        begin
          cmd_d = sdram_cmd_pkg::cmd_load_mode;
          a_d = mode_word;
          ba_d = 2'b00;
          delay_load = 1'b1;
          delay_count = delay_w'(1); // tmrd of two cycles
          state_d = sdram_cmd_pkg::st_init_mode;
        end
      sdram_cmd_pkg::st_idle:
        if (refresh_due)
        begin
          cmd_d = sdram_cmd_pkg::cmd_refresh;
          refresh_clr = 1'b1;
          delay_load = 1'b1;
          delay_count = delay_w'(t_rfc - 1);
          state_d = sdram_cmd_pkg::st_refresh;
        end
        else if (mem_req)
        begin
          cmd_d = sdram_cmd_pkg::cmd_active;
          ba_d = bank;
          a_d = row;
          delay_load = 1'b1;
          delay_count = delay_w'(t_rcd - 1);
          state_d = sdram_cmd_pkg::st_activate;
        end
      sdram_cmd_pkg::st_activate:
        if (delay_done)
        begin
          a_d = {2'b00, 1'b1, 1'b0, col}; // a10 high, auto precharge
          delay_load = 1'b1;
          if (mem_we)
          begin
            cmd_d = sdram_cmd_pkg::cmd_write;
            oe_d = 1'b1;
            delay_count = delay_w'(t_rp);
            state_d = sdram_cmd_pkg::st_precharge;
          end
          else
          begin
            cmd_d = sdram_cmd_pkg::cmd_read;
            delay_count = delay_w'(cas_lat - 1);
            state_d = sdram_cmd_pkg::st_cas_wait;
          end
        end
      sdram_cmd_pkg::st_capture:
      begin
        capture = 1'b1; // dq_in is valid cas_lat cycles after the read command
        delay_load = 1'b1;
        delay_count = delay_w'(t_rp - 1);
        state_d = sdram_cmd_pkg::st_precharge;
      end
      sdram_cmd_pkg::st_precharge:
        if (delay_done)
        begin
          ack_d = 1'b1;
          state_d = sdram_cmd_pkg::st_ack;
        end
      sdram_cmd_pkg::st_ack:
        if (!mem_req)
        begin
          ack_d = 1'b0;
          state_d = sdram_cmd_pkg::st_idle;
        end
      default: // init_mode, refresh and cas_wait only wait out the timer
        if (delay_done)
          state_d = (state == sdram_cmd_pkg::st_cas_wait) ? sdram_cmd_pkg::st_capture
                                                          : sdram_cmd_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= sdram_cmd_pkg::st_reset;
      cmd_q <= sdram_cmd_pkg::cmd_nop;
      sdram_cke <= 1'b0;
      sdram_dq_oe <= 1'b0;
      mem_ack <= 1'b0;
    end
    else
    begin
      state <= state_d;
      cmd_q <= cmd_d;
      sdram_cke <= cke_d;
      sdram_dq_oe <= oe_d;
      mem_ack <= ack_d;
    end
  end

  always_ff @(posedge clk)
  begin
    sdram_ba <= ba_d;
    sdram_a <= a_d;
    sdram_dq_out <= mem_wdata; // lines up with the write command
    if (capture)
      mem_rdata <= sdram_dq_in;
  end

endmodule

//--- logic/sdram_timer.sv
`timescale 1ns/1ps

module sdram_timer #(
  parameter int refresh_cycles = 780,
  parameter int delay_w = 14
) (
  input  logic clk,
  input  logic rst,
  input  logic delay_load,
  input  logic [delay_w-1:0] delay_count,
  output logic delay_done,
  input  logic refresh_clr,
  output logic refresh_due
);

  localparam int ref_w = $clog2(refresh_cycles);

  logic [delay_w-1:0] delay_cnt;
  logic [ref_w-1:0] ref_cnt;
  logic ref_tick;

  assign delay_done = (delay_cnt == '0);
  assign ref_tick = (ref_cnt == ref_w'(refresh_cycles - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
      delay_cnt <= '0;
    else if (delay_load)
      delay_cnt <= delay_count;
    else if (!delay_done)
      delay_cnt <= delay_cnt - 1'b1; // stops at zero
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ref_cnt <= '0;
      refresh_due <= 1'b0;
    end
    else
    begin
      ref_cnt <= ref_tick ? '0 : ref_cnt + 1'b1;
      if (ref_tick)
        refresh_due <= 1'b1; // a new tick beats a clear
      else if (refresh_clr)
        refresh_due <= 1'b0;
    end
  end

endmodule

//--- logic/spi_mem_pkg.sv
package spi_mem_pkg;

  // one SPI data byte
  typedef logic [7:0] mem_byte_t;

  // one SDRAM word, high byte at even byte address
  typedef logic [15:0] mem_word_t;

  // SPI byte address
  // [31:24] region, [23:1] word address, [0] byte select (0 = high byte)
  typedef logic [31:0] spi_addr_t;

  // word address towards the sequencer
  typedef logic [22:0] word_addr_t;

  // region codes in spi_addr_t[31:24]
  localparam mem_byte_t region_mem = 8'h00;
  localparam mem_byte_t region_ctrl = 8'hFF;

endpackage

//--- logic/spi_rw_slave.sv
`timescale 1ns/1ps

module spi_rw_slave (
  input  logic clk,
  input  logic rst,
  input  logic csn,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  output logic byte_req,
  output logic byte_we,
  output spi_mem_pkg::spi_addr_t byte_addr,
  output spi_mem_pkg::mem_byte_t byte_wdata,
  input  logic byte_ack,
  input  spi_mem_pkg::mem_byte_t byte_rdata
);

  typedef enum logic [1:0] {ph_cmd, ph_addr, ph_data} phase_t;

  logic [1:0] csn_sync, sclk_sync, mosi_sync;
  logic sclk_q;
  logic csn_s, mosi_s, sclk_rise, sclk_fall;
  phase_t phase;
  logic [2:0] bit_cnt;
  logic [1:0] addr_cnt; // address bytes seen
  logic is_read;
  logic pending; // request waiting for the previous handshake to close
  spi_mem_pkg::mem_byte_t rx_sr, rx_next, tx_sr, rd_byte;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      csn_sync <= 2'b11;
      sclk_sync <= 2'b00;
      mosi_sync <= 2'b00;
      sclk_q <= 1'b0;
    end
    else
    begin
      csn_sync <= {csn_sync[0], csn};
      sclk_sync <= {sclk_sync[0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_q <= sclk_sync[1];
    end
  end

  assign csn_s = csn_sync[1];
  assign mosi_s = mosi_sync[1]; // same delay as sclk
  assign sclk_rise = sclk_sync[1] & ~sclk_q;
  assign sclk_fall = ~sclk_sync[1] & sclk_q;
  assign rx_next = {rx_sr[6:0], mosi_s};
  assign miso = tx_sr[7];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase <= ph_cmd;
      bit_cnt <= '0;
      addr_cnt <= '0;
      is_read <= 1'b0;
      pending <= 1'b0;
      byte_req <= 1'b0;
      byte_we <= 1'b0;
    end
    else
    begin
      // handshake keeps running after csn rises so an open request finishes
      if (pending && !byte_req && !byte_ack)
      begin
        byte_req <= 1'b1;
        byte_we <= !is_read;
        pending <= 1'b0;
      end
      else if (byte_req && byte_ack)
      begin
        byte_req <= 1'b0;
        byte_addr <= byte_addr + 32'd1; // next byte address
        rd_byte <= byte_rdata;
      end
      if (csn_s)
      begin
        phase <= ph_cmd;
        bit_cnt <= '0;
      end
      else if (sclk_rise)
      begin
        rx_sr <= rx_next;
        bit_cnt <= bit_cnt + 3'd1;
        if (phase == ph_addr)
          byte_addr <= {byte_addr[30:0], mosi_s}; // msb first
        if (bit_cnt == 3'd7)
        begin
          case (phase)
            ph_cmd:
            begin
              is_read <= rx_next[0];
              addr_cnt <= '0;
              phase <= ph_addr;
            end
            ph_addr:
            begin
              addr_cnt <= addr_cnt + 2'd1;
              if (addr_cnt == 2'd3)
              begin
                phase <= ph_data;
                pending <= is_read; // fetch first read byte
              end
            end
            default:
            begin
              byte_wdata <= rx_next;
              pending <= 1'b1;
            end
          endcase
        end
      end
    end
  end

  // mode 0 transmit, new byte goes out on the falling edge at a byte boundary
  always_ff @(posedge clk)
  begin
    if (rst || csn_s)
      tx_sr <= '0;
    else if (sclk_fall)
    begin
      if (bit_cnt == 3'd0 && phase == ph_data && is_read)
        tx_sr <= rd_byte;
      else
        tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

endmodule

//--- logic/spi_sdram_top.sv
`timescale 1ns/1ps

module spi_sdram_top #(
  parameter int t_rcd = 2,
  parameter int cas_lat = 2,
  parameter int t_rp = 2,
  parameter int t_rfc = 7,
  parameter int refresh_cycles = 780,
  parameter int init_cycles = 10000
) (
  input  logic clk,
  input  logic rst,
  input  logic spi_csn,
  input  logic spi_sclk,
  input  logic spi_mosi,
  output logic spi_miso,
  output spi_mem_pkg::mem_byte_t ctrl,
  output logic sdram_cke,
  output logic sdram_csn,
  output logic sdram_rasn,
  output logic sdram_casn,
  output logic sdram_wen,
  output sdram_cmd_pkg::bank_t sdram_ba,
  output sdram_cmd_pkg::row_t sdram_a,
  output logic [1:0] sdram_dqm,
  output spi_mem_pkg::mem_word_t sdram_dq_out,
  output logic sdram_dq_oe,
  input  spi_mem_pkg::mem_word_t sdram_dq_in
);

  // sum bounds the largest delay the sequencer loads
  localparam int delay_w = $clog2(init_cycles + t_rfc + t_rcd + t_rp + cas_lat + 1);

  logic byte_req, byte_we, byte_ack;
  spi_mem_pkg::spi_addr_t byte_addr;
  spi_mem_pkg::mem_byte_t byte_wdata, byte_rdata;
  logic mem_req, mem_we, mem_ack;
  spi_mem_pkg::word_addr_t mem_addr;
  spi_mem_pkg::mem_word_t mem_wdata, mem_rdata;
  logic delay_load, delay_done, refresh_due, refresh_clr;
  logic [delay_w-1:0] delay_count;

  spi_rw_slave u_slave (
    .clk(clk), .rst(rst), .csn(spi_csn), .sclk(spi_sclk), .mosi(spi_mosi),
    .miso(spi_miso), .byte_req(byte_req), .byte_we(byte_we), .byte_addr(byte_addr),
    .byte_wdata(byte_wdata), .byte_ack(byte_ack), .byte_rdata(byte_rdata)
  );

  word_packer u_packer (
    .clk(clk), .rst(rst), .byte_req(byte_req), .byte_we(byte_we), .byte_addr(byte_addr),
    .byte_wdata(byte_wdata), .byte_ack(byte_ack), .byte_rdata(byte_rdata),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .ctrl(ctrl)
  );

  sdram_seq #(
    .t_rcd(t_rcd), .cas_lat(cas_lat), .t_rp(t_rp), .t_rfc(t_rfc),
    .init_cycles(init_cycles), .delay_w(delay_w)
  ) u_seq (
    .clk(clk), .rst(rst), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
    .delay_load(delay_load), .delay_count(delay_count), .delay_done(delay_done),
    .refresh_due(refresh_due), .refresh_clr(refresh_clr),
    .sdram_cke(sdram_cke), .sdram_csn(sdram_csn), .sdram_rasn(sdram_rasn),
    .sdram_casn(sdram_casn), .sdram_wen(sdram_wen), .sdram_ba(sdram_ba),
    .sdram_a(sdram_a), .sdram_dqm(sdram_dqm), .sdram_dq_out(sdram_dq_out),
    .sdram_dq_oe(sdram_dq_oe), .sdram_dq_in(sdram_dq_in)
  );

  sdram_timer #(
    .refresh_cycles(refresh_cycles), .delay_w(delay_w)
  ) u_timer (
    .clk(clk), .rst(rst), .delay_load(delay_load), .delay_count(delay_count),
    .delay_done(delay_done), .refresh_clr(refresh_clr), .refresh_due(refresh_due)
  );

endmodule

//--- logic/word_packer.sv
`timescale 1ns/1ps

module word_packer (
  input  logic clk,
  input  logic rst,
  input  logic byte_req,
  input  logic byte_we,
  input  spi_mem_pkg::spi_addr_t byte_addr,
  input  spi_mem_pkg::mem_byte_t byte_wdata,
  output logic byte_ack,
  output spi_mem_pkg::mem_byte_t byte_rdata,
  output logic mem_req,
  output logic mem_we,
  output spi_mem_pkg::word_addr_t mem_addr,
  output spi_mem_pkg::mem_word_t mem_wdata,
  input  logic mem_ack,
  input  spi_mem_pkg::mem_word_t mem_rdata,
  output spi_mem_pkg::mem_byte_t ctrl
);

  typedef enum logic [1:0] {pk_idle, pk_mem, pk_ack} pk_state_t;

  pk_state_t state;
  spi_mem_pkg::mem_byte_t hi_byte; // even byte waiting for its partner
  spi_mem_pkg::mem_byte_t region;

  assign region = byte_addr[31:24];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= pk_idle;
      byte_ack <= 1'b0;
      mem_req <= 1'b0;
      mem_we <= 1'b0;
      ctrl <= '0;
    end
    else
    begin
      case (state)
        pk_idle:
          // mem_ack low means the sequencer closed the last access
          if (byte_req && !mem_ack)
          begin
            if (region == spi_mem_pkg::region_mem)
            begin
              if (byte_we && !byte_addr[0])
              begin
                hi_byte <= byte_wdata;
                byte_ack <= 1'b1;
                state <= pk_ack;
              end
              else
              begin
                mem_req <= 1'b1;
                mem_we <= byte_we;
                mem_addr <= byte_addr[23:1];
                mem_wdata <= {hi_byte, byte_wdata};
                state <= pk_mem;
              end
            end
            else
            begin
              if (region == spi_mem_pkg::region_ctrl && byte_we)
                ctrl <= byte_wdata;
              byte_rdata <= (region == spi_mem_pkg::region_ctrl) ? ctrl : 8'h00;
              byte_ack <= 1'b1;
              state <= pk_ack;
            end
          end
        pk_mem:
          if (mem_ack)
          begin
            mem_req <= 1'b0;
            if (!mem_we)
              byte_rdata <= byte_addr[0] ? mem_rdata[7:0] : mem_rdata[15:8];
            byte_ack <= 1'b1;
            state <= pk_ack;
          end
        default:
          if (!byte_req)
          begin
            byte_ack <= 1'b0;
            state <= pk_idle;
          end
      endcase
    end
  end

endmodule

//--- sim/sdram_model.sv
`timescale 1ns/1ps

module sdram_model #(
  parameter int cas_lat = 2
) (
  input  logic clk,
  input  logic cke,
  input  logic csn,
  input  logic rasn,
  input  logic casn,
  input  logic wen,
  input  sdram_cmd_pkg::bank_t ba,
  input  sdram_cmd_pkg::row_t a,
  input  spi_mem_pkg::mem_word_t dq_out,
  input  logic dq_oe,
  output spi_mem_pkg::mem_word_t dq_in
);

  spi_mem_pkg::mem_word_t store [logic [23:0]];
  sdram_cmd_pkg::row_t open_row [4];
  spi_mem_pkg::mem_word_t rd_pipe [cas_lat];
  logic [3:0] cmd;
  logic [23:0] key;

  assign cmd = {csn, rasn, casn, wen};
  assign key = {ba, open_row[ba], a[8:0]}; // bank, row, column
  assign dq_in = rd_pipe[cas_lat-1];

  // unwritten words return a pattern built from every key bit
  function automatic spi_mem_pkg::mem_word_t word_at(input logic [23:0] k);
    if (store.exists(k))
      return store[k];
    return k[15:0] ^ {k[23:16], k[23:16]} ^ 16'h5a5a;
  endfunction

  always @(posedge clk)
  begin
    if (cke && cmd == sdram_cmd_pkg::cmd_active)
      open_row[ba] <= a;
    if (cke && cmd == sdram_cmd_pkg::cmd_write && dq_oe)
      store[key] = dq_out;
    rd_pipe[0] <= (cke && cmd == sdram_cmd_pkg::cmd_read) ? word_at(key) : 'x;
    for (int i = 1; i < cas_lat; i++)
      rd_pipe[i] <= rd_pipe[i-1];
  end

endmodule

//--- sim/spi_sdram_chk.sv
`timescale 1ns/1ps

module spi_sdram_chk #(
  parameter int field_w = 8
) (
  input logic clk,
  input logic rst,
  input logic req,
  input logic ack,
  input logic [field_w-1:0] fields,
  input logic [3:0] cmd
);

  logic mode_loaded;
  logic fired = 1'b0; // sticky, set by any failing property

  always_ff @(posedge clk)
  begin
    if (rst)
      mode_loaded <= 1'b0;
    else if (cmd == sdram_cmd_pkg::cmd_load_mode)
      mode_loaded <= 1'b1;
  end

  fields_held: assert property (
    @(posedge clk) disable iff (rst) $past(req) && req |-> $stable(fields))
  else
  begin
    $error("request fields changed while req was high");
    fired = 1'b1;
  end

  ack_under_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
  else
  begin
    $error("ack rose without a pending req");
    fired = 1'b1;
  end

  // row and column commands only once the mode register is set
  access_after_mode: assert property (
    @(posedge clk) disable iff (rst)
    (cmd == sdram_cmd_pkg::cmd_active || cmd == sdram_cmd_pkg::cmd_read ||
     cmd == sdram_cmd_pkg::cmd_write) |-> mode_loaded)
  else
  begin
    $error("access command issued before load_mode");
    fired = 1'b1;
  end

endmodule

//--- sim/tb_spi_sdram.sv
`timescale 1ns/1ps

module tb_spi_sdram;

  localparam int t_rcd = 2;
  localparam int cas_lat = 2;
  localparam int t_rp = 2;
  localparam int t_rfc = 7;
  localparam int refresh_cycles = 160;
  localparam int init_cycles = 200;
  localparam int sclk_half = 32; // clk cycles per sclk half period
  localparam int idle_cycles = 2000;
  localparam int link_timeout = 200;

  logic clk;
  logic rst;
  logic spi_csn;
  logic spi_sclk;
  logic spi_mosi;
  logic spi_miso;
  spi_mem_pkg::mem_byte_t ctrl;
  logic sdram_cke;
  logic sdram_csn;
  logic sdram_rasn;
  logic sdram_casn;
  logic sdram_wen;
  sdram_cmd_pkg::bank_t sdram_ba;
  sdram_cmd_pkg::row_t sdram_a;
  logic [1:0] sdram_dqm;
  spi_mem_pkg::mem_word_t sdram_dq_out;
  logic sdram_dq_oe;
  spi_mem_pkg::mem_word_t sdram_dq_in;

  // reference state updated by the packer rules
  spi_mem_pkg::mem_byte_t ref_mem [logic [23:0]];
  spi_mem_pkg::mem_byte_t ref_hi;
  spi_mem_pkg::mem_byte_t ref_ctrl;

  spi_sdram_top #(
    .t_rcd(t_rcd), .cas_lat(cas_lat), .t_rp(t_rp), .t_rfc(t_rfc),
    .refresh_cycles(refresh_cycles), .init_cycles(init_cycles)
  ) dut (
    .clk(clk), .rst(rst), .spi_csn(spi_csn), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi),
    .spi_miso(spi_miso), .ctrl(ctrl), .sdram_cke(sdram_cke), .sdram_csn(sdram_csn),
    .sdram_rasn(sdram_rasn), .sdram_casn(sdram_casn), .sdram_wen(sdram_wen),
    .sdram_ba(sdram_ba), .sdram_a(sdram_a), .sdram_dqm(sdram_dqm),
    .sdram_dq_out(sdram_dq_out), .sdram_dq_oe(sdram_dq_oe), .sdram_dq_in(sdram_dq_in)
  );

  sdram_model #(.cas_lat(cas_lat)) u_sdram (
    .clk(clk), .cke(sdram_cke), .csn(sdram_csn), .rasn(sdram_rasn), .casn(sdram_casn),
    .wen(sdram_wen), .ba(sdram_ba), .a(sdram_a), .dq_out(sdram_dq_out),
    .dq_oe(sdram_dq_oe), .dq_in(sdram_dq_in)
  );

  bind sdram_seq spi_sdram_chk #(.field_w(40)) u_chk (
    .clk(clk), .rst(rst), .req(mem_req), .ack(mem_ack),
    .fields({mem_we, mem_addr, mem_wdata}),
    .cmd({sdram_csn, sdram_rasn, sdram_casn, sdram_wen})
  );

  bind word_packer spi_sdram_chk #(.field_w(41)) u_chk (
    .clk(clk), .rst(rst), .req(byte_req), .ack(byte_ack),
    .fields({byte_we, byte_addr, byte_wdata}), .cmd(sdram_cmd_pkg::cmd_nop)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  always @(posedge clk)
  begin
    if (dut.u_seq.u_chk.fired || dut.u_packer.u_chk.fired)
      report_failure("a bound assertion fired");
  end

  // byte masks are not used
  always @(negedge clk)
  begin
    if (sdram_dqm !== 2'b00)
      report_failure("sdram_dqm was not held at zero");
  end

  task automatic check_byte(input string name, input spi_mem_pkg::mem_byte_t exp,
                            input spi_mem_pkg::mem_byte_t act);
    if (act !== exp)
    begin
      $display("** Error [%s] expected %h actual %h", name, exp, act);
      report_failure("read data mismatch");
    end
  endtask

  task automatic check_ctrl(input string name, input spi_mem_pkg::mem_byte_t exp,
                            input spi_mem_pkg::mem_byte_t act);
    if (act !== exp)
    begin
      $display("** Error [%s] expected %h actual %h", name, exp, act);
      report_failure("ctrl register mismatch");
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act,
                             input bit at_least);
    if (at_least ? (act < exp) : (act != exp))
    begin
      $display("** Error [%s] expected %s%0d actual %0d", name, at_least ? ">= " : "",
               exp, act);
      report_failure("count mismatch");
    end
  endtask

  function automatic logic [3:0] pin_cmd();
    return {sdram_csn, sdram_rasn, sdram_casn, sdram_wen};
  endfunction

  task automatic apply_write_rule(input spi_mem_pkg::spi_addr_t addr,
                                  input spi_mem_pkg::mem_byte_t b);
    if (addr[31:24] == spi_mem_pkg::region_mem)
    begin
      if (!addr[0])
        ref_hi = b; // waits for the odd byte
      else
      begin
        ref_mem[{addr[23:1], 1'b0}] = ref_hi;
        ref_mem[addr[23:0]] = b;
      end
    end
    else if (addr[31:24] == spi_mem_pkg::region_ctrl)
      ref_ctrl = b;
  endtask

  function automatic spi_mem_pkg::mem_byte_t expected_byte(input spi_mem_pkg::spi_addr_t addr);
    if (addr[31:24] == spi_mem_pkg::region_ctrl)
      return ref_ctrl;
    if (addr[31:24] != spi_mem_pkg::region_mem || !ref_mem.exists(addr[23:0]))
      return (addr[31:24] == spi_mem_pkg::region_mem) ? 8'hxx : 8'h00;
    return ref_mem[addr[23:0]];
  endfunction

  // mode 0 with one bit per sclk period and miso taken just before the rising edge
  task automatic xfer_byte(input spi_mem_pkg::mem_byte_t tx,
                           output spi_mem_pkg::mem_byte_t rx);
    for (int i = 7; i >= 0; i--)
    begin
      spi_mosi = tx[i];
      repeat (sclk_half) @(negedge clk);
      rx[i] = spi_miso;
      spi_sclk = 1'b1;
      repeat (sclk_half) @(negedge clk);
      spi_sclk = 1'b0;
    end
  endtask

  task automatic wait_link_idle();
    int n;
    n = 0;
    while ((dut.byte_req || dut.byte_ack || dut.mem_req || dut.mem_ack) && n < link_timeout)
    begin
      @(negedge clk);
      n++;
    end
    if (dut.byte_req || dut.byte_ack || dut.mem_req || dut.mem_ack)
      report_failure("handshakes did not return to idle after the frame");
  endtask

  task automatic start_frame(input spi_mem_pkg::mem_byte_t cmd,
                             input spi_mem_pkg::spi_addr_t addr);
    spi_mem_pkg::mem_byte_t rx;
    spi_csn = 1'b0;
    repeat (sclk_half) @(negedge clk);
    xfer_byte(cmd, rx);
    for (int i = 3; i >= 0; i--)
      xfer_byte(addr[8*i +: 8], rx); // msb first
  endtask

  task automatic end_frame();
    repeat (sclk_half) @(negedge clk);
    spi_csn = 1'b1;
    wait_link_idle();
    repeat (sclk_half) @(negedge clk);
  endtask

  task automatic write_frame(input spi_mem_pkg::spi_addr_t addr,
                             input spi_mem_pkg::mem_byte_t data[$]);
    spi_mem_pkg::mem_byte_t rx;
    spi_mem_pkg::spi_addr_t cur;
    cur = addr;
    start_frame(8'h02, addr);
    foreach (data[i])
    begin
      xfer_byte(data[i], rx);
      apply_write_rule(cur, data[i]);
      cur = cur + 32'd1;
    end
    end_frame();
  endtask

  task automatic verify_frame(input string name, input spi_mem_pkg::spi_addr_t addr,
                              input int n);
    spi_mem_pkg::mem_byte_t rx;
    spi_mem_pkg::spi_addr_t cur;
    cur = addr;
    start_frame(8'h03, addr);
    for (int i = 0; i < n; i++)
    begin
      xfer_byte(8'h00, rx);
      check_byte(name, expected_byte(cur), rx);
      cur = cur + 32'd1;
    end
    end_frame();
  endtask

  initial
  begin
    spi_mem_pkg::spi_addr_t addr;
    spi_mem_pkg::spi_addr_t frame_addr[$];
    spi_mem_pkg::mem_byte_t data[$];
    spi_mem_pkg::mem_byte_t region;
    logic [23:0] lo;
    int frame_len[$];
    int len;
    int n;
    int nref;

    void'($urandom(32'hbc0a));
    rst = 1'b1;
    spi_csn = 1'b1;
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    ref_ctrl = 8'h00;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // cke low and only nop until init_cycles have passed
    n = 0;
    while (!sdram_cke && n <= init_cycles + 10)
    begin
      if (pin_cmd() != sdram_cmd_pkg::cmd_nop)
        report_failure("a command other than nop appeared while cke was low");
      n++;
      @(negedge clk);
    end
    check_count("cke low after reset", init_cycles, n, 1'b0);
    check_ctrl("ctrl after reset", 8'h00, ctrl);
    if (pin_cmd() != sdram_cmd_pkg::cmd_precharge)
      report_failure("first command after cke high was not precharge");

    n = 0;
    nref = 0;
    while (pin_cmd() != sdram_cmd_pkg::cmd_load_mode && n < 100)
    begin
      @(negedge clk);
      if (pin_cmd() == sdram_cmd_pkg::cmd_refresh)
        nref++;
      n++;
    end
    if (pin_cmd() != sdram_cmd_pkg::cmd_load_mode)
      report_failure("load_mode was not issued after the init wait");
    if (sdram_a[6:4] !== 3'(cas_lat) || sdram_a[2:0] !== 3'b000)
      report_failure("mode word does not hold the cas latency and a burst length of 1");
    check_count("init refresh commands", 2, nref, 1'b0);

    // even-length writes at even region 0 addresses
    repeat (4)
    begin
      lo = 24'($urandom % 32'hFFF000);
      lo[0] = 1'b0;
      addr = {spi_mem_pkg::region_mem, lo};
      len = 2 * (1 + int'($urandom % 4));
      data = {};
      for (int i = 0; i < len; i++)
        data.push_back(8'($urandom));
      write_frame(addr, data);
      verify_frame("random write readback", addr, len);
      frame_addr.push_back(addr);
      frame_len.push_back(len);
    end

    // odd-length frame leaves its last even byte latched
    lo = 24'($urandom % 32'hFFF000);
    lo[0] = 1'b0;
    addr = {spi_mem_pkg::region_mem, lo};
    data = {8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom)};
    write_frame(addr, data);
    data = {8'($urandom), 8'($urandom), 8'($urandom)};
    write_frame(addr, data);
    verify_frame("odd-length write tail", addr, 4);

    data = {8'($urandom) | 8'h01};
    write_frame({spi_mem_pkg::region_ctrl, 24'h000000}, data);
    check_ctrl("ctrl after write", ref_ctrl, ctrl);
    verify_frame("ctrl readback", {spi_mem_pkg::region_ctrl, 24'h000000}, 1);

    // a region other than 0x00 and 0xFF
    region = 8'(1 + $urandom % 254);
    addr = {region, frame_addr[0][23:0]};
    verify_frame("other region read", addr, 2);
    data = {8'($urandom), 8'($urandom)};
    write_frame(addr, data);
    verify_frame("region 0 after other region write", frame_addr[0], frame_len[0]);

    nref = 0;
    for (int i = 0; i < idle_cycles; i++)
    begin
      @(negedge clk);
      if (pin_cmd() == sdram_cmd_pkg::cmd_refresh)
        nref++;
    end
    check_count("refresh commands in idle window", idle_cycles / refresh_cycles - 1,
                nref, 1'b1);
    foreach (frame_addr[i])
      verify_frame("readback after idle window", frame_addr[i], frame_len[i]);

    if (dut.u_seq.u_chk.fired || dut.u_packer.u_chk.fired)
      report_failure("a bound assertion fired");
    else
    begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule
